//--- bench/frame_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame link checker
// expected results, comparison and per-test summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module frame_checker #(
	parameter int clks_per_bit = `UF_CLKS_PER_BIT
) (
	input logic sys_clk,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic uart_txd
);
	// the "&" character
	localparam logic [7:0] DELIM = 8'h26;

	string test_name = "none";
	int test_errs = 0;
	int pass_count = 0;
	int fail_count = 0;
	int slverr_seen = 0;
	logic [7:0] mon_byte;
	logic [7:0] tx_bytes [$];

	// expected {rxbuf words 3..0, status} for a frame held in the rx buffer
	function automatic logic [159:0] ref_result(input logic [127:0] payload, input int len,
		input logic exp_ready, input logic exp_error, input logic exp_overrun);
		logic [31:0] status;
		status = 32'd0;
		status[1] = exp_ready;
		status[2] = exp_error;
		status[3] = exp_overrun;
		status[12:8] = 5'(len);
		// lowest byte of each word is the earliest payload byte
		return {payload, status};
	endfunction

	// bytes of rxbuf word w that belong to the frame
	function automatic logic [31:0] byte_mask(input int len, input int w);
		logic [31:0] m;
		m = '0;
		for (int i = 0; i < 4; i++)
			if (4 * w + i < len)
				m[8*i +: 8] = 8'hff;
		return m;
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %08h actual %08h", test_name, what,
				expected, actual);
			test_errs++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s passed", test_name);
		end else begin
			fail_count++;
			$display("test %s failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic check_frame(input logic [127:0] payload, input int len,
		input logic exp_ready, input logic exp_error, input logic exp_overrun,
		input logic [31:0] status, input logic [127:0] rxbuf);
		logic [159:0] expected;
		logic [31:0] m;
		expected = ref_result(payload, len, exp_ready, exp_error, exp_overrun);
		compare("status", expected[31:0], status);
		for (int w = 0; w < 4; w++) begin
			m = byte_mask(len, w);
			compare($sformatf("rxbuf word %0d", w), expected[32 + 32*w +: 32] & m,
				rxbuf[32*w +: 32] & m);
		end
	endtask

	task automatic clear_tx();
		tx_bytes.delete();
	endtask

	// line should carry && payload &&
	task automatic check_tx_frame(input logic [127:0] payload, input int len);
		logic [7:0] exp_byte;
		compare("tx byte count", len + 4, tx_bytes.size());
		if (tx_bytes.size() == len + 4) begin
			for (int i = 0; i < len + 4; i++) begin
				exp_byte = (i < 2 || i >= len + 2) ? DELIM : payload[8*(i-2) +: 8];
				compare($sformatf("tx byte %0d", i), exp_byte, tx_bytes[i]);
			end
		end
	endtask

	task automatic report_totals();
		$display("tests passed %0d, tests failed %0d", pass_count, fail_count);
	endtask

	// pready and pslverr in access cycles
	always @(negedge sys_clk) begin
		if (psel && penable && pslverr)
			slverr_seen <= slverr_seen + 1;
		if (psel && penable && pready !== 1'b1)
			report_problem("pready was low in an access cycle");
	end

	// serial monitor on uart_txd, mid-bit sampling
	always begin
		@(negedge uart_txd);
		repeat (clks_per_bit / 2) @(posedge sys_clk);
		if (uart_txd == 1'b0) begin
			for (int i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(posedge sys_clk);
				mon_byte[i] = uart_txd;
			end
			repeat (clks_per_bit) @(posedge sys_clk);
			if (uart_txd)
				tx_bytes.push_back(mon_byte);
			else
				report_problem("stop bit on the tx line was low");
		end
	end

endmodule

//--- bench/tb_uart_frame_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart frame link testbench
// APB driver, loopback and serial stimulus, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module tb_uart_frame_link;
	localparam int CPB = `UF_CLKS_PER_BIT;
	localparam int BYTE_CLKS = 10 * CPB;
	// frame transfers across all tests
	localparam int NUM_FRAMES = 10;
	localparam longint LIMIT_NS = NUM_FRAMES * 20 * 10 * CPB * 10 + 100000;
	// a status poll takes three clocks, allow 25 byte times
	localparam int POLL_LIMIT = 25 * BYTE_CLKS / 3;
	// the "&" character
	localparam logic [7:0] DELIM = 8'h26;

	logic sys_clk = 1'b0;
	logic sys_rst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;
	wire uart_txd;
	wire uart_rxd;
	logic loop_sel;
	logic ser_rxd;
	logic [31:0] rng;
	logic [127:0] payload;
	logic [127:0] last_payload;
	int len;
	int last_len;
	logic [31:0] rd_data;
	logic [31:0] status;
	logic [127:0] rxbuf;

	// loopback or serial stimulus
	assign uart_rxd = loop_sel ? uart_txd : ser_rxd;

	uart_frame_link dut (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd)
	);

	frame_checker #(.clks_per_bit(CPB)) chk (
		.sys_clk(sys_clk), .psel(psel), .penable(penable), .pready(pready),
		.pslverr(pslverr), .uart_txd(uart_txd)
	);

	always #5 sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic make_payload();
		logic [7:0] b;
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			b = rng[7:0];
			if (b == DELIM)
				b = 8'h5a;
			payload[8*i +: 8] = b;
		end
	endtask

	task automatic random_len();
		rng = xorshift(rng);
		len = int'(rng[3:0]) + 1;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge sys_clk);
		penable <= 1'b1;
		@(posedge sys_clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge sys_clk);
		penable <= 1'b1;
		// mid access cycle
		@(negedge sys_clk);
		data = prdata;
		@(posedge sys_clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic send_frame(input logic [127:0] data, input int n);
		for (int w = 0; w < 4; w++)
			apb_write(`UF_REG_TXBUF + 8'(4 * w), data[32*w +: 32]);
		apb_write(`UF_REG_CTRL, {19'd0, 5'(n), 7'd0, 1'b1});
	endtask

	task automatic clear_flags();
		apb_write(`UF_REG_STATUS, 32'h0000_000e);
	endtask

	task automatic wait_status(input logic [31:0] mask, input logic [31:0] want);
		int polls;
		polls = 0;
		apb_read(`UF_REG_STATUS, status);
		while ((status & mask) !== want && polls < POLL_LIMIT) begin
			apb_read(`UF_REG_STATUS, status);
			polls++;
		end
		if ((status & mask) !== want)
			chk.report_problem("timed out waiting for the status flags");
	endtask

	task automatic read_results();
		logic [31:0] word;
		apb_read(`UF_REG_STATUS, status);
		for (int w = 0; w < 4; w++) begin
			apb_read(`UF_REG_RXBUF + 8'(4 * w), word);
			rxbuf[32*w +: 32] = word;
		end
	endtask

	// one 8N1 byte on the stimulus line
	task automatic send_serial(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			ser_rxd <= bits[i];
			repeat (CPB - 1) @(posedge sys_clk);
		end
	endtask

	initial begin
		#(LIMIT_NS);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		sys_rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		loop_sel = 1'b1;
		ser_rxd = 1'b1;
		rng = 32'd75;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (2) @(posedge sys_clk);

		chk.begin_test("txbuf_access");
		make_payload();
		for (int w = 0; w < 4; w++)
			apb_write(`UF_REG_TXBUF + 8'(4 * w), payload[32*w +: 32]);
		for (int w = 0; w < 4; w++) begin
			apb_read(`UF_REG_TXBUF + 8'(4 * w), rd_data);
			chk.compare($sformatf("txbuf word %0d", w), payload[32*w +: 32], rd_data);
		end
		apb_read(8'h08, rd_data);
		chk.compare("unmapped read data", 32'd0, rd_data);
		// only the unmapped access may flag a slave error
		chk.compare("pslverr count", 32'd1, chk.slverr_seen);
		chk.end_test();

		for (int f = 0; f < 4; f++) begin
			chk.begin_test($sformatf("loopback_%0d", f));
			make_payload();
			random_len();
			clear_flags();
			chk.clear_tx();
			send_frame(payload, len);
			wait_status(32'h3, 32'h2);
			read_results();
			chk.check_frame(payload, len, 1'b1, 1'b0, 1'b0, status, rxbuf);
			chk.check_tx_frame(payload, len);
			chk.end_test();
		end
		last_payload = payload;
		last_len = len;

		// a lone & followed by C
		chk.begin_test("lone_delimiter");
		clear_flags();
		loop_sel <= 1'b0;
		send_serial(DELIM);
		send_serial(DELIM);
		send_serial(8'h41);
		send_serial(8'h42);
		send_serial(DELIM);
		send_serial(8'h43);
		wait_status(32'h4, 32'h4);
		read_results();
		chk.check_frame(last_payload, last_len, 1'b0, 1'b1, 1'b0, status, rxbuf);
		chk.end_test();

		chk.begin_test("too_long");
		clear_flags();
		send_serial(DELIM);
		send_serial(DELIM);
		make_payload();
		for (int i = 0; i < 17; i++)
			send_serial(i < 16 ? payload[8*i +: 8] : 8'h58);
		wait_status(32'h4, 32'h4);
		read_results();
		chk.check_frame(last_payload, last_len, 1'b0, 1'b1, 1'b0, status, rxbuf);
		chk.end_test();

		chk.begin_test("overrun");
		loop_sel <= 1'b1;
		clear_flags();
		make_payload();
		random_len();
		last_payload = payload;
		last_len = len;
		send_frame(payload, len);
		wait_status(32'h3, 32'h2);
		make_payload();
		random_len();
		send_frame(payload, len);
		wait_status(32'h9, 32'h8);
		read_results();
		chk.check_frame(last_payload, last_len, 1'b1, 1'b0, 1'b1, status, rxbuf);
		chk.end_test();

		// rx_length still holds the nonzero overrun frame here
		chk.begin_test("zero_length");
		clear_flags();
		chk.clear_tx();
		send_frame(payload, 0);
		wait_status(32'h3, 32'h2);
		read_results();
		chk.check_frame(payload, 0, 1'b1, 1'b0, 1'b0, status, rxbuf);
		chk.check_tx_frame(payload, 0);
		chk.end_test();

		chk.begin_test("start_while_busy");
		clear_flags();
		chk.clear_tx();
		make_payload();
		random_len();
		send_frame(payload, len);
		repeat (3 * CPB) @(posedge sys_clk);
		apb_write(`UF_REG_CTRL, {19'd0, 5'(len), 7'd0, 1'b1});
		wait_status(32'h3, 32'h2);
		// room for a second frame to show up on the line
		repeat (4 * BYTE_CLKS) @(posedge sys_clk);
		read_results();
		chk.check_frame(payload, len, 1'b1, 1'b0, 1'b0, status, rxbuf);
		chk.check_tx_frame(payload, len);
		chk.end_test();

		chk.report_totals();
		if (chk.fail_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- logic/apb_frame_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB frame registers
// control, status, tx buffer and rx buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module apb_frame_regs (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic [7:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	frame_tx_if.regs ftx,
	frame_rx_if.regs frx
);
	import uart_frame_pkg::*;

	logic access, wr_acc, aligned;
	logic hit_ctrl, hit_status, hit_txbuf, hit_rxbuf;
	logic [1:0] word_sel;
	frame_len_t ctrl_len, rx_len;
	logic rx_ready, rx_error, rx_overrun;
	logic frame_accept;
	uart_byte_t tx_buf [`UF_MAX_LEN];
	uart_byte_t rx_stage [`UF_MAX_LEN];
	uart_byte_t rx_buf [`UF_MAX_LEN];

	assign access = psel && penable;
	assign wr_acc = access && pwrite;
	assign aligned = (paddr[1:0] == 2'b00);
	assign word_sel = paddr[3:2];
	assign hit_ctrl = aligned && (paddr == `UF_REG_CTRL);
	assign hit_status = aligned && (paddr == `UF_REG_STATUS);
	assign hit_txbuf = aligned && (paddr[7:4] == 4'(`UF_REG_TXBUF >> 4));
	assign hit_rxbuf = aligned && (paddr[7:4] == 4'(`UF_REG_RXBUF >> 4));

	// no wait states
	assign pready = 1'b1;
	assign pslverr = access && !(hit_ctrl || hit_status || hit_txbuf || hit_rxbuf);

	// start fires in the access cycle itself
	assign ftx.start = wr_acc && hit_ctrl && pwdata[0];
	assign ftx.length = ctrl_len;
	assign ftx.rd_byte = tx_buf[ftx.rd_index];

	// a finished frame only lands while the buffer is free
	assign frame_accept = frx.frame_done && !rx_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ctrl_len <= '0;
			rx_len <= '0;
			rx_ready <= 1'b0;
			rx_error <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			if (wr_acc && hit_ctrl)
				ctrl_len <= (pwdata[12:8] > frame_len_t'(`UF_MAX_LEN)) ?
					frame_len_t'(`UF_MAX_LEN) : pwdata[12:8];
			// write one to clear, new events win
			if (wr_acc && hit_status) begin
				if (pwdata[1])
					rx_ready <= 1'b0;
				if (pwdata[2])
					rx_error <= 1'b0;
				if (pwdata[3])
					rx_overrun <= 1'b0;
			end
			if (frame_accept) begin
				rx_ready <= 1'b1;
				rx_len <= frx.length;
			end
			if (frx.frame_done && rx_ready)
				rx_overrun <= 1'b1;
			if (frx.frame_error)
				rx_error <= 1'b1;
		end
	end

	// byte storage
	always_ff @(posedge sys_clk) begin
		if (wr_acc && hit_txbuf) begin
			for (int b = 0; b < 4; b++)
				tx_buf[{word_sel, 2'(b)}] <= pwdata[8*b +: 8];
		end
		// staging keeps RXBUF intact across bad frames
		if (frx.wr_en && !rx_ready)
			rx_stage[frx.wr_index] <= frx.wr_byte;
		if (frame_accept)
			rx_buf <= rx_stage;
	end

	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata[12:8] = ctrl_len;
		else if (hit_status)
			prdata = {19'd0, rx_len, 4'd0, rx_overrun, rx_error, rx_ready, ftx.busy};
		else if (hit_txbuf || hit_rxbuf) begin
			for (int b = 0; b < 4; b++)
				prdata[8*b +: 8] = hit_txbuf ? tx_buf[{word_sel, 2'(b)}] :
					rx_buf[{word_sel, 2'(b)}];
		end
	end

endmodule

//--- logic/frame_link_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame link interfaces
// register block to tx sequencer and rx decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface frame_tx_if;
	import uart_frame_pkg::*;

	logic start;
	frame_len_t length;
	uart_byte_t rd_byte;
	frame_index_t rd_index;
	logic busy;
	logic done;

	modport regs (output start, output length, output rd_byte,
		input rd_index, input busy, input done);
	modport seq (input start, input length, input rd_byte,
		output rd_index, output busy, output done);
endinterface

interface frame_rx_if;
	import uart_frame_pkg::*;

	logic wr_en;
	frame_index_t wr_index;
	uart_byte_t wr_byte;
	logic frame_done;
	logic frame_error;
	frame_len_t length;

	modport dec (output wr_en, output wr_index, output wr_byte,
		output frame_done, output frame_error, output length);
	modport regs (input wr_en, input wr_index, input wr_byte,
		input frame_done, input frame_error, input length);
endinterface

//--- logic/frame_rx_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame rx decoder
// finds && delimiters and writes out payload bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module frame_rx_decoder (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic rx_vld,
	input  uart_frame_pkg::uart_byte_t rx_data,
	frame_rx_if.dec frx
);
	import uart_frame_pkg::*;

	localparam logic [1:0] S_HUNT = 2'd0;
	localparam logic [1:0] S_OPEN = 2'd1;
	localparam logic [1:0] S_PAYLOAD = 2'd2;
	localparam logic [1:0] S_CLOSE = 2'd3;

	logic [1:0] state;
	frame_len_t len;
	logic is_delim;

	assign is_delim = (rx_data == FRAME_DELIM);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_HUNT;
			len <= '0;
			frx.wr_en <= 1'b0;
			frx.frame_done <= 1'b0;
			frx.frame_error <= 1'b0;
		end else begin
			frx.wr_en <= 1'b0;
			frx.frame_done <= 1'b0;
			frx.frame_error <= 1'b0;
			if (rx_vld) begin
				case (state)
					S_HUNT: if (is_delim)
						state <= S_OPEN;
					S_OPEN: begin
						len <= '0;
						state <= is_delim ? S_PAYLOAD : S_HUNT;
						frx.frame_error <= !is_delim;
					end
					S_PAYLOAD: begin
						if (is_delim) begin
							state <= S_CLOSE;
						end else if (len == frame_len_t'(`UF_MAX_LEN)) begin
							// 17th payload byte
							state <= S_HUNT;
							frx.frame_error <= 1'b1;
						end else begin
							frx.wr_en <= 1'b1;
							len <= len + 5'd1;
						end
					end
					default: begin
						// lone & inside payload is an error
						state <= S_HUNT;
						frx.frame_done <= is_delim;
						frx.frame_error <= !is_delim;
					end
				endcase
			end
		end
	end

	// byte and position for the write strobe
	always_ff @(posedge sys_clk) begin
		if (rx_vld && state == S_PAYLOAD) begin
			frx.wr_byte <= rx_data;
			frx.wr_index <= len[3:0];
		end
	end

	assign frx.length = len;

endmodule

//--- logic/frame_tx_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame tx sequencer
// sends &&, the payload bytes, then && via uart_tx
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module frame_tx_sequencer (
	input  logic sys_clk,
	input  logic sys_rst_n,
	frame_tx_if.seq ftx,
	output logic tx_req,
	output uart_frame_pkg::uart_byte_t tx_data,
	input  logic tx_done
);
	import uart_frame_pkg::*;

	localparam logic [6:0] S_IDLE = 7'b000_0001;
	localparam logic [6:0] S_OPEN1 = 7'b000_0010;
	localparam logic [6:0] S_OPEN2 = 7'b000_0100;
	localparam logic [6:0] S_PAYLOAD = 7'b000_1000;
	localparam logic [6:0] S_CLOSE1 = 7'b001_0000;
	localparam logic [6:0] S_CLOSE2 = 7'b010_0000;
	localparam logic [6:0] S_FINISH = 7'b100_0000;

	logic [6:0] state;
	logic busy;
	frame_index_t rd_index;
	frame_len_t sent_cnt;
	frame_len_t len_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			busy <= 1'b0;
			tx_req <= 1'b0;
			tx_data <= '0;
			rd_index <= '0;
			sent_cnt <= '0;
			len_q <= '0;
		end else begin
			tx_req <= 1'b0;
			case (state)
				S_IDLE: if (ftx.start) begin
					state <= S_OPEN1;
					busy <= 1'b1;
					tx_req <= 1'b1;
					tx_data <= FRAME_DELIM;
					rd_index <= '0;
					sent_cnt <= '0;
				end
				// length register is settled by now
				S_OPEN1: if (tx_done) begin
					state <= S_OPEN2;
					tx_req <= 1'b1;
					tx_data <= FRAME_DELIM;
					len_q <= ftx.length;
				end
				S_OPEN2, S_PAYLOAD: if (tx_done) begin
					tx_req <= 1'b1;
					if (sent_cnt == len_q) begin
						// all bytes out, or empty payload
						state <= S_CLOSE1;
						tx_data <= FRAME_DELIM;
					end else begin
						state <= S_PAYLOAD;
						tx_data <= ftx.rd_byte;
						rd_index <= rd_index + 4'd1;
						sent_cnt <= sent_cnt + 5'd1;
					end
				end
				S_CLOSE1: if (tx_done) begin
					state <= S_CLOSE2;
					tx_req <= 1'b1;
					tx_data <= FRAME_DELIM;
				end
				S_CLOSE2: if (tx_done) begin
					state <= S_FINISH;
					busy <= 1'b0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign ftx.rd_index = rd_index;
	assign ftx.busy = busy;
	assign ftx.done = (state == S_FINISH);

endmodule

//--- logic/uart_frame_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart frame link defines
// bit period, payload limit and APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UART_FRAME_DEFINES_SVH
`define UART_FRAME_DEFINES_SVH

`define UF_CLKS_PER_BIT 16
`define UF_MAX_LEN 16

// byte offsets, buffers are four words each
`define UF_REG_CTRL 8'h00
`define UF_REG_STATUS 8'h04
`define UF_REG_TXBUF 8'h10
`define UF_REG_RXBUF 8'h20

`endif

//--- logic/uart_frame_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart frame link top
// APB register front end over a framed 8N1 link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module uart_frame_link #(
	parameter int clks_per_bit = `UF_CLKS_PER_BIT
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic [7:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic uart_rxd,
	output logic uart_txd
);
	import uart_frame_pkg::*;

	logic tx_req, tx_done, rx_vld;
	uart_byte_t tx_data, rx_data;

	frame_tx_if ftx ();
	frame_rx_if frx ();

	apb_frame_regs u_regs (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ftx(ftx.regs), .frx(frx.regs)
	);

	// execute side
	frame_tx_sequencer u_seq (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .ftx(ftx.seq),
		.tx_req(tx_req), .tx_data(tx_data), .tx_done(tx_done)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .tx_req(tx_req),
		.tx_data(tx_data), .txd(uart_txd), .tx_done(tx_done)
	);

	// decode side
	uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .rxd(uart_rxd),
		.rx_data(rx_data), .rx_vld(rx_vld)
	);

	frame_rx_decoder u_dec (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .rx_vld(rx_vld),
		.rx_data(rx_data), .frx(frx.dec)
	);

endmodule

//--- logic/uart_frame_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart frame link package
// shared byte, length and index types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_frame_pkg;

	// one serial data byte
	typedef logic [7:0] uart_byte_t;

	// payload length, 0 to 16
	typedef logic [4:0] frame_len_t;

	// position inside a 16 byte buffer
	typedef logic [3:0] frame_index_t;

	// opening and closing delimiter character
	localparam uart_byte_t FRAME_DELIM = 8'h26;

endpackage

//--- logic/uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart receiver
// 8N1 byte capture with mid-bit sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module uart_rx #(
	parameter int clks_per_bit = `UF_CLKS_PER_BIT
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic rxd,
	output uart_frame_pkg::uart_byte_t rx_data,
	output logic rx_vld
);
	import uart_frame_pkg::*;

	localparam int CW = $clog2(clks_per_bit);
	localparam logic [CW-1:0] LAST_CLK = CW'(clks_per_bit - 1);
	localparam logic [CW-1:0] HALF_CLK = CW'(clks_per_bit / 2 - 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	logic rx_s1, rx_s2, rx_prev;
	logic [1:0] state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	uart_byte_t shift;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_s1 <= rxd;
			rx_s2 <= rx_s1;
			rx_prev <= rx_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_s2)
						state <= S_START;
				end
				// start bit must still be low at half period
				S_START: if (clk_cnt == HALF_CLK) begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= rx_s2 ? S_IDLE : S_DATA;
				end
				S_DATA: if (clk_cnt == LAST_CLK) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= S_STOP;
				end
				default: if (clk_cnt == LAST_CLK) begin
					rx_vld <= rx_s2;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && clk_cnt == LAST_CLK)
			shift <= {rx_s2, shift[7:1]};
	end

	assign rx_data = shift;

endmodule

//--- logic/uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart transmitter
// sends one 8N1 byte per request, lsb first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "uart_frame_defines.svh"

module uart_tx #(
	parameter int clks_per_bit = `UF_CLKS_PER_BIT
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic tx_req,
	input  uart_frame_pkg::uart_byte_t tx_data,
	output logic txd,
	output logic tx_done
);
	localparam int CW = $clog2(clks_per_bit);
	localparam logic [CW-1:0] LAST_CLK = CW'(clks_per_bit - 1);

	logic busy;
	logic [CW-1:0] clk_cnt;
	logic [3:0] bit_cnt;
	// stop, data, start from msb to lsb
	logic [9:0] shift;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift <= '1;
		end else if (!busy) begin
			if (tx_req) begin
				busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
				shift <= {1'b1, tx_data, 1'b0};
			end
		end else if (clk_cnt == LAST_CLK) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
				shift <= {1'b1, shift[9:1]};
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// line idles high
	assign txd = busy ? shift[0] : 1'b1;

	// last clock of the stop bit
	assign tx_done = busy && (bit_cnt == 4'd9) && (clk_cnt == LAST_CLK);

endmodule

//--- uart_frame_link.f
+incdir+logic
logic/uart_frame_pkg.sv
logic/frame_link_if.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_tx_sequencer.sv
logic/frame_rx_decoder.sv
logic/apb_frame_regs.sv
logic/uart_frame_link.sv
bench/frame_checker.sv
bench/tb_uart_frame_link.sv
